/* rv_testdata.hex */
// Instruction count, then the program words
// RAM word count, then RAM words; store count, then address and data pairs
00000027
00500093 FFD00113 002081B3 10302023
40208233 10402223 401152B3 10502423
00115333 10602623 001123B3 00113433
10702823 10802A23 123454B7 6784C513
10A02C23 0F057593 00459613 10C02E23
00002683 00168733 12E02023 00700013
12002223 00108463 12102423 00208463
12102623 00209463 12202823 00109463
12202A23 00900793 00F78833 00F808B3
13102C23 13002E23 00000063
// Initial RAM
00000002
00001000 DEADBEEF
// Expected stores
0000000E
00000100 00000002
00000104 00000008
00000108 FFFFFFFF
0000010C 07FFFFFF
00000110 00000001
00000114 00000000
00000118 12345678
0000011C 00000700
00000120 00001005
00000124 00000000
0000012C 00000005
00000134 FFFFFFFD
00000138 0000001B
0000013C 00000012

/* build.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_hazard_unit.sv
rv_execute.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_rv_core
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell grep -v '^+' $(FILELIST)) rv_config.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* tb_rv_core.sv */
// Testbench for the RV32I pipeline
// Loads program, RAM image and expected stores from rv_testdata.hex and checks every store

`timescale 1ns/1ps

`include "rv_config.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int FILE_WORDS = 1024;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    dmem_req_t        dmem_req;
    logic [`XLEN-1:0] dmem_rdata;

    logic [`XLEN-1:0] file_words [0:FILE_WORDS-1];
    logic [`XLEN-1:0] rom [0:MEM_WORDS-1];
    logic [`XLEN-1:0] ram [0:MEM_WORDS-1];
    logic [`XLEN-1:0] exp_addr [0:MEM_WORDS-1];
    logic [`XLEN-1:0] exp_data [0:MEM_WORDS-1];

    int n_instr;
    int n_ram;
    int n_store;
    int store_idx;
    int timeout_cycles;

    rv_core UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // ==============================
    // Clock and memory models
    // ==============================
    always #10 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_data  = rom[imem_addr[9:2]];
    // Read data only while a read is requested
    assign dmem_rdata = dmem_req.re ? ram[dmem_req.addr[9:2]] : '0;

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Store monitor sampled at the edge that commits the write
    always @(posedge clk) begin
        if (dmem_req.we === 1'b1) begin
            if (reset)
                fail_run("A store appeared while reset was asserted");
            else if (store_idx >= n_store)
                fail_run($sformatf("Unexpected extra store to address %08h", dmem_req.addr));
            else begin
                check_value($sformatf("store %0d address", store_idx),
                            exp_addr[store_idx], dmem_req.addr);
                check_value($sformatf("store %0d data", store_idx),
                            exp_data[store_idx], dmem_req.wdata);
                ram[dmem_req.addr[9:2]] = dmem_req.wdata;
                store_idx = store_idx + 1;
            end
        end
    end

    // ==============================
    // Image loading
    // ==============================
    task automatic load_image();
        int ptr;
        for (int i = 0; i < FILE_WORDS; i++)
            file_words[i] = '0;
        $readmemh("rv_testdata.hex", file_words);
        n_instr = file_words[0];
        if (n_instr < 1 || n_instr > MEM_WORDS)
            fail_run("Instruction count in the data file is out of range");
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = `NOP_INSTR;
            // Unused RAM words hold random data
            ram[i] = $urandom;
        end
        for (int i = 0; i < n_instr; i++)
            rom[i] = file_words[1 + i];
        ptr = 1 + n_instr;
        n_ram = file_words[ptr];
        ptr++;
        for (int i = 0; i < n_ram; i++)
            ram[i] = file_words[ptr + i];
        ptr += n_ram;
        n_store = file_words[ptr];
        ptr++;
        if (n_store < 1 || n_store > MEM_WORDS)
            fail_run("Store count in the data file is out of range");
        for (int i = 0; i < n_store; i++) begin
            exp_addr[i] = file_words[ptr + 2 * i];
            exp_data[i] = file_words[ptr + 2 * i + 1];
        end
    endtask

    task automatic watchdog();
        repeat (timeout_cycles) @(posedge clk);
        fail_run($sformatf("Timeout: only %0d of %0d expected stores arrived",
                           store_idx, n_store));
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        void'($urandom(32'hbc40_1b14));
        clk       = 1'b0;
        reset     = 1'b1;
        store_idx = 0;
        n_store   = 0;
        load_image();
        timeout_cycles = 8 * (n_instr + n_store) + 100;
        fork
            watchdog();
        join_none
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        wait (store_idx == n_store);
        // Quiet period in which any further store is an error
        repeat (20) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* rv_core_chk.sv */
// Concurrent checks on the core ports, bound into rv_core
// Reports only through assertion failures

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_core_chk (
    input logic                clk,
    input logic                reset,
    input logic [`XLEN-1:0]    imem_addr,
    input rv_pkg::dmem_req_t   dmem_req
);

    import rv_pkg::*;

    no_read_write_overlap: assert property (@(posedge clk) disable iff (reset)
        !(dmem_req.we && dmem_req.re))
        else $error("dmem read and write requested in the same cycle");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    // First cycle out of reset carries only bubbles
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!dmem_req.we && !dmem_req.re))
        else $error("memory access right after reset");

    no_unknown_ports: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(dmem_req) && !$isunknown(imem_addr))
        else $error("X on core memory ports");

endmodule

bind rv_core rv_core_chk chk (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req)
);

/* rv_core.sv */
// Five-stage RV32I pipeline top level
// Instruction and data memories answer combinationally in the same cycle

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`XLEN-1:0]    imem_addr,
    input  logic [`XLEN-1:0]    imem_data,
    output rv_pkg::dmem_req_t   dmem_req,
    input  logic [`XLEN-1:0]    dmem_rdata
);

    import rv_pkg::*;

    logic [`XLEN-1:0]       pc;
    instr_u                 if_id_instr;
    logic [`XLEN-1:0]       if_id_pc;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    mem_wb_t                mem_wb;

    ctrl_t                  dec_ctrl;
    logic [`XLEN-1:0]       dec_imm;
    logic [`REG_ADDR_W-1:0] dec_rs1;
    logic [`REG_ADDR_W-1:0] dec_rs2;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic [`XLEN-1:0]       rf_rs1_data;
    logic [`XLEN-1:0]       rf_rs2_data;

    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
    logic                   stall;
    logic                   flush;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
    logic [`XLEN-1:0]       wb_data;

    // ==============================
    // IF
    // ==============================
    // A taken branch redirects in the cycle EX resolves it
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= `RESET_PC;
        else if (flush)
            pc <= branch_target;
        else if (!stall)
            pc <= pc + 32'd4;
    end

    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id_instr <= `NOP_INSTR;
            if_id_pc    <= `RESET_PC;
        end else if (flush) begin
            if_id_instr <= `NOP_INSTR;
        end else if (!stall) begin
            if_id_instr <= imem_data;
            if_id_pc    <= pc;
        end
    end

    // ==============================
    // ID
    // ==============================
    rv_decode u_decode (
        .instr (if_id_instr),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .rd    (dec_rd)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (mem_wb.reg_write),
        .wr_addr  (mem_wb.rd),
        .wr_data  (wb_data)
    );

    rv_hazard_unit u_hazard (
        .id_rs1        (dec_rs1),
        .id_rs2        (dec_rs2),
        .ex_rs1        (id_ex.rs1),
        .ex_rs2        (id_ex.rs2),
        .ex_rd         (id_ex.rd),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .mem_rd        (ex_mem.rd),
        .mem_reg_write (ex_mem.reg_write),
        .wb_rd         (mem_wb.rd),
        .wb_reg_write  (mem_wb.reg_write),
        .branch_taken  (branch_taken),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    // Bubble on a load-use stall or a flush
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (flush || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{ctrl: dec_ctrl, pc: if_id_pc,
                       rs1_data: rf_rs1_data, rs2_data: rf_rs2_data,
                       imm: dec_imm, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd};
        end
    end

    // ==============================
    // EX
    // ==============================
    rv_execute u_execute (
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (ex_mem.alu_result),
        .wb_data       (wb_data),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{reg_write: id_ex.ctrl.reg_write, mem_read: id_ex.ctrl.mem_read,
                        mem_write: id_ex.ctrl.mem_write, alu_result: alu_result,
                        store_data: store_data, rd: id_ex.rd};
        end
    end

    // ==============================
    // MEM
    // ==============================
    assign dmem_req = '{addr: ex_mem.alu_result, wdata: ex_mem.store_data,
                        we: ex_mem.mem_write, re: ex_mem.mem_read};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{reg_write: ex_mem.reg_write, mem_to_reg: ex_mem.mem_read,
                        alu_result: ex_mem.alu_result, load_data: dmem_rdata,
                        rd: ex_mem.rd};
        end
    end

    // ==============================
    // WB
    // ==============================
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

/* rv_execute.sv */
// EX stage: operand forwarding, ALU and branch resolution
// Combinational, fed from ID/EX and the later stage results

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_execute (
    input  rv_pkg::id_ex_t      id_ex,
    input  rv_pkg::fwd_sel_e    fwd_a,
    input  rv_pkg::fwd_sel_e    fwd_b,
    input  logic [`XLEN-1:0]    mem_result,
    input  logic [`XLEN-1:0]    wb_data,
    output logic [`XLEN-1:0]    alu_result,
    output logic [`XLEN-1:0]    store_data,
    output logic                branch_taken,
    output logic [`XLEN-1:0]    branch_target
);

    import rv_pkg::*;

    logic [`XLEN-1:0] fwd_a_val;
    logic [`XLEN-1:0] fwd_b_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_val,
                                                 input logic [`XLEN-1:0] mem_val,
                                                 input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ==============================
    // Operand selection
    // ==============================
    assign fwd_a_val = fwd_mux(fwd_a, id_ex.rs1_data, mem_result, wb_data);
    assign fwd_b_val = fwd_mux(fwd_b, id_ex.rs2_data, mem_result, wb_data);

    // LUI adds its immediate to zero
    assign op_a  = id_ex.ctrl.zero_a ? '0 : fwd_a_val;
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b_val;
    assign shamt = op_b[4:0];

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // ==============================
    // Branch resolution
    // ==============================
    // BEQ on equal, BNE on not equal
    assign branch_taken  = id_ex.ctrl.branch &&
                           ((fwd_a_val == fwd_b_val) ^ id_ex.ctrl.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    assign store_data = fwd_b_val;

endmodule

/* rv_hazard_unit.sv */
// Forwarding selects, load-use stall and branch flush
// Purely combinational, driven from the ID, EX, MEM and WB stage fields

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_hazard_unit (
    input  logic [`REG_ADDR_W-1:0]  id_rs1,
    input  logic [`REG_ADDR_W-1:0]  id_rs2,
    input  logic [`REG_ADDR_W-1:0]  ex_rs1,
    input  logic [`REG_ADDR_W-1:0]  ex_rs2,
    input  logic [`REG_ADDR_W-1:0]  ex_rd,
    input  logic                    ex_mem_read,
    input  logic [`REG_ADDR_W-1:0]  mem_rd,
    input  logic                    mem_reg_write,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic                    wb_reg_write,
    input  logic                    branch_taken,
    output rv_pkg::fwd_sel_e        fwd_a,
    output rv_pkg::fwd_sel_e        fwd_b,
    output logic                    stall,
    output logic                    flush
);

    import rv_pkg::*;

    logic load_use;

    // MEM holds the younger result, so it wins over WB
    function automatic fwd_sel_e select_src(input logic [`REG_ADDR_W-1:0] rs,
                                            input logic [`REG_ADDR_W-1:0] m_rd,
                                            input logic m_we,
                                            input logic [`REG_ADDR_W-1:0] w_rd,
                                            input logic w_we);
        if (rs == '0)
            return FWD_NONE;
        if (m_we && (m_rd == rs))
            return FWD_MEM;
        if (w_we && (w_rd == rs))
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign fwd_a = select_src(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    assign fwd_b = select_src(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

    assign load_use = ex_mem_read && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    // A taken branch discards the stalled instruction anyway
    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

endmodule

/* rv_regfile.sv */
// Integer register file with x0 hardwired to zero
// Reads see a write to the same register in the same cycle

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  rs1,
    input  logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  logic                    we,
    input  logic [`REG_ADDR_W-1:0]  wr_addr,
    input  logic [`XLEN-1:0]        wr_data
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (we && (wr_addr == addr))
            return wr_data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Re-evaluated on any register, write port or address change
    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

/* rv_decode.sv */
// Instruction decoder of the ID stage
// Produces control fields, register indices and the sign-extended immediate

`timescale 1ns/1ps

`include "rv_config.svh"

module rv_decode (
    input  rv_pkg::instr_u          instr,
    output rv_pkg::ctrl_t           ctrl,
    output logic [`XLEN-1:0]        imm,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`REG_ADDR_W-1:0]  rd
);

    import rv_pkg::*;

    // alt selects SUB over ADD and SRA over SRL
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr.r.opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct3(instr.r.funct3, instr.r.funct7[5]);
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                // Only the right shifts use bit 30 as an operation bit
                ctrl.alu_op = alu_from_funct3(instr.i.funct3,
                    (instr.i.funct3 == 3'b101) && instr.r.funct7[5]);
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.zero_a      = 1'b1;
                imm = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
            end
            LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            BRANCH: begin
                // BEQ and BNE only
                if (instr.b.funct3[2:1] == 2'b00) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = instr.b.funct3[0];
                    imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                           instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* rv_pkg.sv */
// Types shared by the pipeline stages
// Opcodes, ALU operations, instruction views and pipeline registers

`include "rv_config.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

    // ==============================
    // Instruction formats
    // ==============================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    // ==============================
    // Control and pipeline registers
    // ==============================
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    zero_a;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_to_reg;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       load_data;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_wb_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             we;
        logic             re;
    } dmem_req_t;

endpackage

/* rv_config.svh */
// Fixed sizes and reset constants of the RV32I pipeline
// Include in any file that needs a width or a reset value

`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ==============================
// Data path
// ==============================
`define XLEN 32

// ==============================
// Register file
// ==============================
`define REG_COUNT 32
`define REG_ADDR_W 5

// ==============================
// Fetch
// ==============================
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
